/* verilog.f */
+incdir+source
source/vec_isa_pkg.sv
source/vec_pe_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_top.sv
verif/vec_checker.sv
verif/vec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module vec_tb

# Keep running after an assertion so the testbench prints its verdict
./obj_dir/Vvec_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

/* verif/vec_tb.sv */
//////////////////////////////
// Directed testbench for vec_top with an element-level model
// of the register file. Run through run.sh.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_defs.svh"

module vec_tb;
  import vec_isa_pkg::*;

  localparam int NR_VREGS     = `NR_VREGS;
  localparam int VLMAX        = `VLMAX;
  localparam int RESET_CYCLES = 5;
  // Commands per test in the order the tests run
  localparam int TOTAL_CMDS   = 136 + 117 + 85 + 51 + 20 + 7;
  localparam int MAX_CYCLES   = 40 * TOTAL_CMDS + 2 * RESET_CYCLES;

  logic      clk_i        = 1'b0;
  logic      reset_i      = 1'b1;
  vec_cmd_t  cmd_i        = '0;
  logic      cmd_valid_i  = 1'b0;
  logic      cmd_ready_o;
  vec_resp_t resp_o;
  logic      resp_valid_o;
  logic      resp_ready_i = 1'b1;

  elem_t       model [NR_VREGS][VLMAX];
  vec_cmd_t    cmd_q [$];
  vec_resp_t   exp_q [$];
  logic [31:0] rng_state   = 32'h8062;
  int          errors      = 0;
  int          checks      = 0;
  int          cycle_count = 0;
  int          total_fail;
  vec_op_e     alu_ops [5] = '{VADD, VSUB, VAND, VOR, VXOR};

  vec_top uut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .resp_o      (resp_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  bind vec_top vec_checker u_checker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .resp_o      (resp_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic elem_t next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
  endfunction

  function automatic vec_cmd_t build_cmd(input vec_op_e op, input int vd, input int vs1,
                                         input int vs2, input logic use_s, input elem_t scalar,
                                         input int vl, input int idx);
    vec_cmd_t c;
    c.op         = op;
    c.vd         = vreg_t'(vd);
    c.vs1        = vreg_t'(vs1);
    c.vs2        = vreg_t'(vs2);
    c.use_scalar = use_s;
    c.scalar     = scalar;
    c.vl         = HOST_LEN_W'(vl);
    c.idx        = HOST_LEN_W'(idx);
    return c;
  endfunction

  // Applies a command to the model and returns the expected response
  function automatic vec_resp_t predict(input vec_cmd_t c);
    vec_resp_t r;
    int        vl;
    int        vd;
    int        vs1;
    int        vs2;
    int        idx;
    elem_t     a;
    elem_t     b;
    r.op     = c.op;
    r.result = '0;
    vd       = int'(c.vd);
    vs1      = int'(c.vs1);
    vs2      = int'(c.vs2);
    vl       = (int'(c.vl) > VLMAX) ? VLMAX : int'(c.vl);
    if (c.op == VMV_XS) begin
      idx = int'(c.idx);
      if (idx < VLMAX) begin
        r.result = model[vs2][idx];
      end
    end else begin
      // Elements at or above vl are left alone
      for (int e = 0; e < vl; e++) begin
        a = model[vs2][e];
        b = c.use_scalar ? c.scalar : model[vs1][e];
        case (c.op)
          VMV_VX:  model[vd][e] = c.scalar;
          VADD:    model[vd][e] = a + b;
          VSUB:    model[vd][e] = a - b;
          VAND:    model[vd][e] = a & b;
          VOR:     model[vd][e] = a | b;
          VXOR:    model[vd][e] = a ^ b;
          default: model[vd][e] = model[vd][e];
        endcase
      end
    end
    return r;
  endfunction

  task automatic queue_cmd(input vec_cmd_t c);
    cmd_q.push_back(c);
    exp_q.push_back(predict(c));
  endtask

  task automatic queue_read(input int vreg, input int idx);
    queue_cmd(build_cmd(VMV_XS, 0, 0, vreg, 1'b0, '0, VLMAX, idx));
  endtask

  task automatic queue_read_all(input int vreg);
    for (int i = 0; i < VLMAX; i++) begin
      queue_read(vreg, i);
    end
  endtask

  // Decreasing vl leaves each element with its own random value
  task automatic fill_random(input int vreg);
    for (int k = VLMAX; k >= 1; k--) begin
      queue_cmd(build_cmd(VMV_VX, vreg, 0, 0, 1'b0, next_rand(), k, 0));
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_elem(input elem_t got, input elem_t exp, input string name);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input vec_resp_t got, input vec_resp_t exp);
    checks++;
    if (got.op !== exp.op) begin
      $display("Mismatch at %0t: resp_o.op got %0d expected %0d", $time, got.op, exp.op);
      errors++;
    end
    check_elem(got.result, exp.result, "resp_o.result");
  endtask

  // Streams the command queue and checks responses until max_resp arrive
  task automatic run_queue(input logic random_ready, input int max_resp);
    int        sent;
    int        got;
    int        total;
    vec_resp_t exp;
    sent  = 0;
    got   = 0;
    total = cmd_q.size();
    while (got < max_resp) begin
      @(posedge clk_i);
      if (cmd_valid_i && cmd_ready_o) begin
        sent++;
      end
      if (resp_valid_o && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t with no command outstanding", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_resp(resp_o, exp);
        end
        got++;
      end
      if (got < max_resp) begin
        cmd_valid_i <= (sent < total);
        if (sent < total) begin
          cmd_i <= cmd_q[sent];
        end
        resp_ready_i <= random_ready ? (rand_below(4) != 0) : 1'b1;
      end
    end
    if (got == total) begin
      cmd_q.delete();
    end
  endtask

  task automatic expect_idle(input int cycles, input logic check_ready);
    repeat (cycles) begin
      @(posedge clk_i);
      if (resp_valid_o !== 1'b0) begin
        $display("Response valid at %0t with no command outstanding", $time);
        errors++;
      end
      if (check_ready && cmd_ready_o !== 1'b1) begin
        $display("Command port not ready at %0t after reset", $time);
        errors++;
      end
    end
  endtask

  task automatic apply_reset();
    reset_i      <= 1'b1;
    cmd_valid_i  <= 1'b0;
    resp_ready_i <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic splat_then_read();
    int e0;
    e0 = errors;
    for (int r = 0; r < NR_VREGS; r++) begin
      queue_cmd(build_cmd(VMV_VX, r, 0, 0, 1'b0, next_rand(), VLMAX, 0));
    end
    for (int r = 0; r < NR_VREGS; r++) begin
      queue_read_all(r);
    end
    run_queue(1'b0, cmd_q.size());
    report_test("splat_then_read", e0);
  endtask

  task automatic vector_vector_alu();
    int e0;
    e0 = errors;
    fill_random(1);
    fill_random(2);
    for (int i = 0; i < 5; i++) begin
      queue_cmd(build_cmd(alu_ops[i], 3 + i, 1, 2, 1'b0, '0, VLMAX, 0));
    end
    for (int r = 3; r < 8; r++) begin
      queue_read_all(r);
    end
    run_queue(1'b0, cmd_q.size());
    report_test("vector_vector_alu", e0);
  endtask

  task automatic vector_scalar_alu();
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      queue_cmd(build_cmd(alu_ops[i], 3 + i, 2, 1, 1'b1, next_rand(), VLMAX, 0));
    end
    for (int r = 3; r < 8; r++) begin
      queue_read_all(r);
    end
    run_queue(1'b0, cmd_q.size());
    report_test("vector_scalar_alu", e0);
  endtask

  task automatic tail_and_clamp();
    int e0;
    e0 = errors;
    // Short vl leaves elements 5 and up with their old values
    queue_cmd(build_cmd(VADD, 4, 1, 2, 1'b0, '0, 5, 0));
    queue_read_all(4);
    // vl above VLMAX is clamped to the full register
    queue_cmd(build_cmd(VXOR, 5, 1, 2, 1'b0, '0, 31, 0));
    queue_read_all(5);
    // Low bits of this vl alone would cover only four elements
    queue_cmd(build_cmd(VSUB, 6, 1, 2, 1'b0, '0, 2 * VLMAX + 4, 0));
    queue_read_all(6);
    run_queue(1'b0, cmd_q.size());
    report_test("tail_and_clamp", e0);
  endtask

  task automatic backpressure_stream();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) begin
        queue_cmd(build_cmd(alu_ops[rand_below(5)], 1 + rand_below(7), rand_below(8),
                            rand_below(8), rand_below(2) == 1, next_rand(),
                            rand_below(24), 0));
      end else begin
        queue_read(rand_below(8), rand_below(VLMAX));
      end
    end
    run_queue(1'b1, 20);
    expect_idle(8, 1'b0);
    report_test("backpressure_stream", e0);
  endtask

  task automatic reset_mid_stream();
    int e0;
    e0 = errors;
    // Only reads here so the register file stays known across the reset
    for (int i = 0; i < 6; i++) begin
      queue_read(rand_below(8), rand_below(VLMAX));
    end
    run_queue(1'b0, 2);
    apply_reset();
    cmd_q.delete();
    exp_q.delete();
    expect_idle(10, 1'b1);
    queue_read(3, 7);
    run_queue(1'b0, 1);
    report_test("reset_mid_stream", e0);
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    splat_then_read();
    vector_vector_alu();
    vector_scalar_alu();
    tail_and_clamp();
    backpressure_stream();
    reset_mid_stream();
    @(posedge clk_i);
    total_fail = errors + int'(uut.u_checker.error_count);
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, uut.u_checker.error_count);
    if (total_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/vec_checker.sv */
//////////////////////////////
// Handshake and reset assertions for the coprocessor ports.
// Bound into vec_top by the testbench.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_checker (
  input logic                   clk_i,
  input logic                   reset_i,
  input vec_isa_pkg::vec_cmd_t  cmd_i,
  input logic                   cmd_valid_i,
  input logic                   cmd_ready_o,
  input vec_isa_pkg::vec_resp_t resp_o,
  input logic                   resp_valid_o,
  input logic                   resp_ready_i
);
  // Failed assertions so far, read by the testbench at the end
  int unsigned error_count = 0;

  // Response held until the host takes it
  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
    else begin
      $error("resp_o changed or dropped while resp_ready_i was low");
      error_count++;
    end

  // Host side of the command port
  a_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      cmd_valid_i && !cmd_ready_o |=> cmd_valid_i && $stable(cmd_i))
    else begin
      $error("cmd_i changed or dropped while cmd_ready_o was low");
      error_count++;
    end

  a_resp_reset: assert property (@(posedge clk_i) reset_i |=> !resp_valid_o)
    else begin
      $error("resp_valid_o high during or right after reset");
      error_count++;
    end

  a_ready_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> cmd_ready_o)
    else begin
      $error("cmd_ready_o low on the first cycle after reset");
      error_count++;
    end

endmodule

`default_nettype wire

/* source/vec_top.sv */
//////////////////////////////
// Coprocessor top level: dispatcher, sequencer and the lane row.
// Host talks to it through the command and response ports.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_defs.svh"

module vec_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  vec_isa_pkg::vec_cmd_t  cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  output vec_isa_pkg::vec_resp_t resp_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i
);
  import vec_isa_pkg::*;
  import vec_pe_pkg::*;

  // Dispatcher to sequencer
  pe_req_t                    pe_req;
  logic                       req_valid;
  logic                       req_ready;
  logic                       done_valid;
  logic                       done_ready;
  elem_t                      done_result;

  // Sequencer to lanes
  pe_req_t                    lane_req;
  logic                       lane_req_valid;
  logic [`NR_LANES-1:0]       lane_req_ready;
  pe_resp_t [`NR_LANES-1:0]   lane_resp;
  logic                       lane_resp_ack;

  vec_dispatcher u_dispatcher (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .req_o        (pe_req),
    .req_valid_o  (req_valid),
    .req_ready_i  (req_ready),
    .done_valid_i (done_valid),
    .done_result_i(done_result),
    .done_ready_o (done_ready),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

  vec_sequencer u_sequencer (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_i           (pe_req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .lane_req_o      (lane_req),
    .lane_req_valid_o(lane_req_valid),
    .lane_req_ready_i(lane_req_ready),
    .lane_resp_i     (lane_resp),
    .lane_resp_ack_o (lane_resp_ack),
    .done_valid_o    (done_valid),
    .done_ready_i    (done_ready),
    .done_result_o   (done_result)
  );

  for (genvar lane = 0; lane < `NR_LANES; lane++) begin : gen_lanes
    vec_lane #(
      .LANE_ID(lane)
    ) u_lane (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (lane_req),
      .req_valid_i(lane_req_valid),
      .req_ready_o(lane_req_ready[lane]),
      .resp_o     (lane_resp[lane]),
      .resp_ack_i (lane_resp_ack)
    );
  end

endmodule

`default_nettype wire

/* source/vec_lane.sv */
//////////////////////////////
// One lane: a slice of the vector register file and its element
// ALU. Instantiated once per lane from the top-level loop.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_defs.svh"

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  vec_pe_pkg::pe_req_t  req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output vec_pe_pkg::pe_resp_t resp_o,
  input  logic                 resp_ack_i
);
  import vec_isa_pkg::*;
  import vec_pe_pkg::*;

  localparam int SLOTS  = `ELEMS_PER_LANE;
  localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int VL_W   = `VL_W;
  localparam int ELEN   = `ELEN;

  // Register file slice, element e sits at slot e / NR_LANES
  elem_t             vrf_q [`NR_VREGS][SLOTS];

  // Two-entry request buffer, the head entry is the one executing
  pe_req_t           buf_q [2];
  logic              rd_ptr_q;
  logic              wr_ptr_q;
  logic [1:0]        count_q;

  lane_state_e       state_q;
  logic [SLOT_W-1:0] slot_q;
  elem_t             result_q;

  pe_req_t           head;
  logic              push;
  logic              pop;
  logic              last_slot;
  logic              xs_hit;
  logic [VL_W-1:0]   gidx;
  elem_t             op_a;
  elem_t             op_b;
  elem_t             alu_res;

  assign req_ready_o = (count_q != 2'd2);
  assign push        = req_valid_i & req_ready_o;
  assign pop         = (state_q == LANE_DONE) & resp_ack_i;
  assign head        = buf_q[rd_ptr_q];
  assign last_slot   = (slot_q == SLOT_W'(SLOTS - 1));

  // Global element index of the current slot
  assign gidx   = VL_W'(slot_q) * VL_W'(`NR_LANES) + VL_W'(LANE_ID);
  assign xs_hit = (head.op == VMV_XS) && (head.scalar == ELEN'(gidx));

  // Element ALU
  always_comb begin
    op_a = vrf_q[head.vs2][slot_q];
    op_b = head.use_scalar ? head.scalar : vrf_q[head.vs1][slot_q];
    case (head.op)
      VMV_VX:  alu_res = head.scalar;
      VADD:    alu_res = op_a + op_b;
      VSUB:    alu_res = op_a - op_b;
      VAND:    alu_res = op_a & op_b;
      VOR:     alu_res = op_a | op_b;
      VXOR:    alu_res = op_a ^ op_b;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////
  // Request buffer
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  //////////////////////////////
  // Slot walk
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= LANE_IDLE;
      slot_q  <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (push) begin
            state_q <= LANE_RUN;
            slot_q  <= '0;
          end
        end
        LANE_RUN: begin
          slot_q <= slot_q + 1'b1;
          if (last_slot) begin
            state_q <= LANE_DONE;
          end
        end
        LANE_DONE: begin
          // Next entry starts right after the ack if one is waiting
          if (resp_ack_i) begin
            slot_q  <= '0;
            state_q <= (count_q == 2'd2 || push) ? LANE_RUN : LANE_IDLE;
          end
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  // Tail elements at or above vl keep their value
  always_ff @(posedge clk_i) begin
    if (state_q == LANE_RUN) begin
      if (head.op != VMV_XS && gidx < head.vl) begin
        vrf_q[head.vd][slot_q] <= alu_res;
      end
      if (xs_hit) begin
        result_q <= op_a;
      end else if (slot_q == '0) begin
        result_q <= '0;
      end
    end
  end

  assign resp_o.done   = (state_q == LANE_DONE);
  assign resp_o.result = result_q;

endmodule

`default_nettype wire

/* source/vec_sequencer.sv */
//////////////////////////////
// Broadcasts requests to the lane row in lockstep and joins
// their completions into a single done with merged result
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_defs.svh"

module vec_sequencer (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  vec_pe_pkg::pe_req_t                 req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  output vec_pe_pkg::pe_req_t                 lane_req_o,
  output logic                                lane_req_valid_o,
  input  logic [`NR_LANES-1:0]                lane_req_ready_i,
  input  vec_pe_pkg::pe_resp_t [`NR_LANES-1:0] lane_resp_i,
  output logic                                lane_resp_ack_o,
  output logic                                done_valid_o,
  input  logic                                done_ready_i,
  output vec_isa_pkg::elem_t                  done_result_o
);
  import vec_isa_pkg::*;
  import vec_pe_pkg::*;

  pe_req_t    req_q;
  logic       req_valid_q;
  logic       all_ready;
  logic       all_done;
  elem_t      merged;
  logic [1:0] outstanding_q;
  logic       issue;

  //////////////////////////////
  // Issue side
  //////////////////////////////

  // All lanes take the request on the same edge
  assign all_ready        = &lane_req_ready_i;
  assign issue            = req_valid_q & all_ready;
  assign lane_req_valid_o = issue;
  assign lane_req_o       = req_q;
  assign req_ready_o      = ~req_valid_q | all_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) begin
      req_q <= req_i;
    end
  end

  //////////////////////////////
  // Completion side
  //////////////////////////////

  // Join of done flags, OR of lane results
  always_comb begin
    all_done = 1'b1;
    merged   = '0;
    for (int i = 0; i < `NR_LANES; i++) begin
      all_done = all_done & lane_resp_i[i].done;
      merged   = merged | lane_resp_i[i].result;
    end
  end

  // A done with nothing outstanding is never forwarded
  assign done_valid_o    = all_done & (outstanding_q != 2'd0);
  assign lane_resp_ack_o = done_valid_o & done_ready_i;
  assign done_result_o   = merged;

  // Each lane buffers at most two requests
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 2'(issue) - 2'(lane_resp_ack_o);
    end
  end

endmodule

`default_nettype wire

/* source/vec_dispatcher.sv */
//////////////////////////////
// Front end of the coprocessor: takes host commands, issues lane
// requests and returns one response per command in order
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_defs.svh"

module vec_dispatcher (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vec_isa_pkg::vec_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  output vec_pe_pkg::pe_req_t     req_o,
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  input  logic                    done_valid_i,
  input  vec_isa_pkg::elem_t      done_result_i,
  output logic                    done_ready_o,
  output vec_isa_pkg::vec_resp_t  resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i
);
  import vec_isa_pkg::*;
  import vec_pe_pkg::*;

  localparam int OPQ_DEPTH = 3;
  localparam int VL_W      = `VL_W;
  localparam int VLMAX     = `VLMAX;
  localparam int ELEN      = `ELEN;

  pe_req_t    req_q;
  pe_req_t    req_d;
  logic       req_valid_q;
  vec_op_e    opq_q [OPQ_DEPTH];
  logic [1:0] opq_wr_q;
  logic [1:0] opq_rd_q;
  logic [1:0] opq_cnt_q;
  vec_resp_t  resp_q;
  logic       resp_valid_q;
  logic       accept;
  logic       done_xfer;

  function automatic logic [1:0] opq_next(input logic [1:0] ptr);
    return (ptr == 2'(OPQ_DEPTH - 1)) ? 2'd0 : ptr + 2'd1;
  endfunction

  // Hold off the host while the request slot or the opcode queue is full
  assign cmd_ready_o  = (~req_valid_q | req_ready_i) & (opq_cnt_q != 2'(OPQ_DEPTH));
  assign accept       = cmd_valid_i & cmd_ready_o;
  assign done_ready_o = ~resp_valid_q | resp_ready_i;
  assign done_xfer    = done_valid_i & done_ready_o;

  // Command to lane request, vl clamped to VLMAX
  always_comb begin
    req_d.op         = cmd_i.op;
    req_d.vd         = cmd_i.vd;
    req_d.vs1        = cmd_i.vs1;
    req_d.vs2        = cmd_i.vs2;
    req_d.use_scalar = cmd_i.use_scalar;
    req_d.scalar     = (cmd_i.op == VMV_XS) ? ELEN'(cmd_i.idx) : cmd_i.scalar;
    if (cmd_i.vl > HOST_LEN_W'(VLMAX)) begin
      req_d.vl = VL_W'(VLMAX);
    end else begin
      req_d.vl = cmd_i.vl[VL_W-1:0];
    end
  end

  //////////////////////////////
  // Request and opcode queue
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
      opq_wr_q    <= '0;
      opq_rd_q    <= '0;
      opq_cnt_q   <= '0;
    end else begin
      if (~req_valid_q | req_ready_i) begin
        req_valid_q <= accept;
      end
      if (accept) begin
        opq_wr_q <= opq_next(opq_wr_q);
      end
      if (done_xfer) begin
        opq_rd_q <= opq_next(opq_rd_q);
      end
      opq_cnt_q <= opq_cnt_q + 2'(accept) - 2'(done_xfer);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q           <= req_d;
      opq_q[opq_wr_q] <= cmd_i.op;
    end
  end

  //////////////////////////////
  // Response register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (done_xfer) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_xfer) begin
      resp_q.result <= done_result_i;
      resp_q.op     <= opq_q[opq_rd_q];
    end
  end

  assign req_o        = req_q;
  assign req_valid_o  = req_valid_q;
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // Sizing must satisfy the header constraints
  if (!(`VEC_CFG_OK)) begin : gen_cfg_check
    $error("vec_dispatcher: inconsistent lane or register sizing");
  end

endmodule

`default_nettype wire

/* source/vec_pe_pkg.sv */
//////////////////////////////
// Internal types between dispatcher, sequencer and lanes
//////////////////////////////

`default_nettype none

`include "vec_defs.svh"

package vec_pe_pkg;

  // Request broadcast to every lane
  // scalar carries the element index for VMV_XS
  typedef struct packed {
    vec_isa_pkg::vec_op_e op;
    vec_isa_pkg::vreg_t   vd;
    vec_isa_pkg::vreg_t   vs1;
    vec_isa_pkg::vreg_t   vs2;
    logic                 use_scalar;
    vec_isa_pkg::elem_t   scalar;
    logic [`VL_W-1:0]     vl;
  } pe_req_t;

  // Per-lane completion, held until acknowledged
  typedef struct packed {
    logic               done;
    vec_isa_pkg::elem_t result;
  } pe_resp_t;

  // Lane execution FSM
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,
    LANE_RUN  = 2'd1,
    LANE_DONE = 2'd2
  } lane_state_e;

endpackage

`default_nettype wire

/* source/vec_isa_pkg.sv */
//////////////////////////////
// Host-visible types: opcodes, command and response words
// exchanged with the coprocessor ports
//////////////////////////////

`default_nettype none

`include "vec_defs.svh"

package vec_isa_pkg;

  // Width of the host vl and idx fields
  localparam int unsigned HOST_LEN_W = 16;

  typedef logic [`ELEN-1:0]   elem_t;
  typedef logic [`VREG_W-1:0] vreg_t;

  // Supported vector operations
  typedef enum logic [2:0] {
    VMV_VX = 3'd0,
    VADD   = 3'd1,
    VSUB   = 3'd2,
    VAND   = 3'd3,
    VOR    = 3'd4,
    VXOR   = 3'd5,
    VMV_XS = 3'd6
  } vec_op_e;

  // Host command
  typedef struct packed {
    vec_op_e               op;
    vreg_t                 vd;
    vreg_t                 vs1;
    vreg_t                 vs2;
    logic                  use_scalar;
    elem_t                 scalar;
    logic [HOST_LEN_W-1:0] vl;
    logic [HOST_LEN_W-1:0] idx;
  } vec_cmd_t;

  // One response per command, in order
  typedef struct packed {
    elem_t   result;
    vec_op_e op;
  } vec_resp_t;

endpackage

`default_nettype wire

/* source/vec_defs.svh */
//////////////////////////////
// Sizing macros for the vector coprocessor, shared by the packages
// and the RTL. Include where a width or a count is needed.
//////////////////////////////

`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Lane row and element size
`define NR_LANES        4
`define ELEN            32

// Register file shape
`define NR_VREGS        8
`define ELEMS_PER_LANE  4
`define VLMAX           (`NR_LANES * `ELEMS_PER_LANE)

// Index widths
`define VREG_W          3
`define VL_W            5

// Static sanity of the sizing above
`define VEC_CFG_OK ((`NR_LANES > 0) && ((`NR_LANES & (`NR_LANES - 1)) == 0) && \
  (`ELEMS_PER_LANE > 0) && ((1 << `VL_W) > `VLMAX) && ((1 << `VREG_W) >= `NR_VREGS))

`endif
